/* logic/tile_attr.sv */
// tile_attr: attribute decode into bank, code and palette, ROM request register
`timescale 1ns/1ps
`default_nettype none

module tile_attr (
    input  wire                          clk,
    input  wire                          rst,
    input  wire tilemap_pkg::tile_cfg_t  cfg,
    input  wire                          pos_valid,
    input  wire tilemap_pkg::tile_pos_t  pos,
    output logic                         pos_ready,
    output logic                         req_valid,
    output tilemap_pkg::tile_req_t       req,
    input  wire                          req_ready,
    input  wire                          flush
);

    logic [4:0]  bank;
    logic [12:0] code;
    logic [3:0]  pal;

    always_comb begin
        bank[0] = pos.attr_scan[7];
        for (int i = 0; i < 4; i++) begin
            if (cfg.extra_en && cfg.extra_mask[i]) begin
                bank[i+1] = cfg.extra_bits[i];      // forced bank bit
            end else begin
                bank[i+1] = pos.attr_scan[3 + cfg.code_sel[i]];
            end
        end
        code = {bank, pos.code_scan};
        pal  = {cfg.pal_msb & pos.attr_scan[3], pos.attr_scan[2:0]};
    end

    assign pos_ready = !req_valid || req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (flush) begin
            req_valid <= 1'b0;
        end else if (pos_ready) begin
            req_valid <= pos_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pos_ready && pos_valid) begin
            req.layer    <= pos.layer;
            req.rom_addr <= {cfg.tile_msb, code, pos.row, pos.half};  // 1+13+3+1
            req.pal      <= pal;
            req.hrender  <= pos.hrender;
            req.last     <= pos.last;
        end
    end

endmodule

`default_nettype wire

/* logic/tile_fetch.sv */
// tile_fetch: graphics ROM read handshake and nibble output to the line buffer
`timescale 1ns/1ps
`default_nettype none

module tile_fetch (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             line,
    input  wire                             req_valid,
    input  wire tilemap_pkg::tile_req_t     req,
    output logic                            req_ready,
    output logic                            rom_cs,
    output logic [tilemap_pkg::rom_aw-1:0]  rom_addr,
    input  wire                             rom_ok,
    input  wire [15:0]                      rom_data,
    output logic                            line_we,
    output tilemap_pkg::line_wr_t           line_wr,
    output logic                            layer_done,
    input  wire                             flush
);

    typedef enum logic [1:0] {f_idle, f_rom, f_dump} state_t;

    state_t                  st;
    tilemap_pkg::tile_req_t  job;
    logic [15:0]             pxl;
    logic [1:0]              cnt;       // nibble within the word

    assign req_ready = (st == f_idle);
    assign rom_addr  = job.rom_addr;    // steady while rom_cs is high

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            st         <= f_idle;
            rom_cs     <= 1'b0;
            line_we    <= 1'b0;
            layer_done <= 1'b0;
        end else begin
            line_we    <= 1'b0;
            layer_done <= 1'b0;
            case (st)
                f_idle: begin
                    if (req_valid) begin
                        rom_cs <= 1'b1;
                        st     <= f_rom;
                    end
                end
                f_rom: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        st     <= f_dump;
                    end
                end
                f_dump: begin
                    line_we <= 1'b1;
                    if (cnt == 2'd3) begin
                        layer_done <= job.last;     // with the fourth write
                        st         <= f_idle;
                    end
                end
                default: st <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            f_idle: begin
                if (req_valid) begin
                    job <= req;
                end
            end
            f_rom: begin
                if (rom_ok) begin
                    pxl <= rom_data;
                    cnt <= 2'd0;
                end
            end
            f_dump: begin
                // upper nibble goes out first
                line_wr.layer <= job.layer;
                line_wr.addr  <= {line, job.hrender};
                line_wr.din   <= {job.pal, pxl[15:12]};
                pxl           <= pxl << 4;
                job.hrender   <= job.hrender + 9'd1;
                cnt           <= cnt + 2'd1;
            end
            default: cnt <= 2'd0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/tile_regs.sv */
// tile_regs: AXI4-Lite slave holding the scroll and layer configuration registers
`timescale 1ns/1ps
`default_nettype none

module tile_regs (
    input  wire                            clk,
    input  wire                            rst,
    input  wire [tilemap_pkg::reg_aw-1:0]  awaddr,
    input  wire                            awvalid,
    output logic                           awready,
    input  wire [31:0]                     wdata,
    input  wire [3:0]                      wstrb,
    input  wire                            wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  wire                            bready,
    input  wire [tilemap_pkg::reg_aw-1:0]  araddr,
    input  wire                            arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  wire                            rready,
    output tilemap_pkg::tile_cfg_t         cfg
);

    logic [31:0] regs [4];
    logic [2:0]  wdec;      // {hit, index}
    logic [2:0]  rdec;

    function automatic logic [2:0] reg_decode(input logic [tilemap_pkg::reg_aw-1:0] addr);
        case (addr)
            tilemap_pkg::reg_scroll: return 3'b100;
            tilemap_pkg::reg_dump:   return 3'b101;
            tilemap_pkg::reg_bank:   return 3'b110;
            tilemap_pkg::reg_misc:   return 3'b111;
            default:                 return 3'b000;   // unmapped
        endcase
    endfunction

    assign wdec  = reg_decode(awaddr);
    assign rdec  = reg_decode(araddr);
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // AW and W are taken in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (awvalid && wvalid && !awready && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            if (awready) begin          // handshake completes here
                bvalid <= 1'b1;
                if (wdec[2]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            regs[wdec[1:0]][8*b +: 8] <= wdata[8*b +: 8];
                        end
                    end
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arready) begin
            rdata <= rdec[2] ? regs[rdec[1:0]] : 32'd0;
        end
    end

    always_comb begin
        cfg.hscroll        = regs[0][8:0];
        cfg.vscroll        = regs[0][23:16];
        cfg.scr_dump_start = regs[1][8:0];
        cfg.chr_dump_start = regs[1][24:16];
        cfg.code_sel       = regs[2][7:0];
        cfg.extra_mask     = regs[2][11:8];
        cfg.extra_bits     = regs[2][15:12];
        cfg.extra_en       = regs[2][16];
        cfg.pal_msb        = regs[3][0];
        cfg.tile_msb       = regs[3][1];
    end

endmodule

`default_nettype wire

/* logic/tile_scan.sv */
// tile_scan: line start detection, layer and slot sequencing, scan RAM reads
`timescale 1ns/1ps
`default_nettype none

module tile_scan #(
    parameter int line_pixels = tilemap_pkg::line_pixels_def
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              lhbl,
    input  wire                              lvbl,
    input  wire [8:0]                        vrender,
    input  wire tilemap_pkg::tile_cfg_t      cfg,
    input  wire                              pos_ready,
    input  wire [7:0]                        code_scan,
    input  wire [7:0]                        attr_scan,
    input  wire                              layer_done,
    output logic [tilemap_pkg::scan_aw-1:0]  scan_addr,
    output logic                             pos_valid,
    output tilemap_pkg::tile_pos_t           pos,
    output logic                             line,
    output logic                             done,
    output logic                             flush
);

    typedef enum logic [1:0] {s_idle, s_addr, s_data, s_hold} state_t;

    state_t      st;
    logic        lhbl_l;
    logic        layer;
    logic        scr_fin;       // scroll layer fully written
    logic [8:0]  hn;
    logic [8:0]  vn;
    logic [8:0]  hrender;
    logic        last;

    assign flush     = lhbl && !lhbl_l && lvbl;     // rising edge of blanking
    assign scan_addr = {layer, vn[7:3], hn[7:3]};
    assign last      = ({1'b0, hrender} + 10'd4) >= 10'(line_pixels);

    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= s_idle;
            lhbl_l    <= 1'b0;
            layer     <= 1'b0;
            scr_fin   <= 1'b0;
            line      <= 1'b0;
            done      <= 1'b1;
            pos_valid <= 1'b0;
        end else begin
            lhbl_l <= lhbl;
            if (flush) begin
                line      <= ~line;
                done      <= 1'b0;
                layer     <= 1'b0;
                scr_fin   <= 1'b0;
                pos_valid <= 1'b0;
                st        <= s_addr;
            end else begin
                // first pulse closes the scroll layer, second the fixed one
                if (layer_done) begin
                    scr_fin <= 1'b1;
                    if (scr_fin) begin
                        done <= 1'b1;
                    end
                end
                case (st)
                    s_addr: st <= s_data;       // RAM reads scan_addr
                    s_data: begin
                        pos_valid <= 1'b1;
                        st        <= s_hold;
                    end
                    s_hold: begin
                        if (pos_ready) begin
                            pos_valid <= 1'b0;
                            if (!last || !layer) begin
                                st <= s_addr;
                            end else begin
                                st <= s_idle;
                            end
                            if (last) begin
                                layer <= 1'b1;
                            end
                        end
                    end
                    default: st <= s_idle;
                endcase
            end
        end
    end

    // position counters, loaded per layer
    always_ff @(posedge clk) begin
        if (flush) begin
            hn      <= cfg.hscroll;
            vn      <= vrender + {1'b0, cfg.vscroll};
            hrender <= cfg.scr_dump_start - {7'd0, cfg.hscroll[1:0]};
        end else if (st == s_hold && pos_ready) begin
            if (last) begin     // fixed layer ignores scroll
                hn      <= 9'd0;
                vn      <= vrender;
                hrender <= cfg.chr_dump_start;
            end else begin
                hn      <= hn + 9'd4;
                hrender <= hrender + 9'd4;
            end
        end
        if (st == s_data) begin
            pos <= '{layer: layer, row: vn[2:0], half: hn[2], hrender: hrender,
                     code_scan: code_scan, attr_scan: attr_scan, last: last};
        end
    end

endmodule

`default_nettype wire

/* logic/tilemap_pkg.sv */
// tilemap package: widths, register offsets and the structs passed between stages
`default_nettype none

package tilemap_pkg;

    localparam int line_pixels_def = 320;
    localparam int rom_aw          = 18;
    localparam int scan_aw         = 11;    // layer, 5 row bits, 5 column bits
    localparam int reg_aw          = 8;     // register port address width

    // register map
    localparam logic [reg_aw-1:0] reg_scroll = 8'h00;  // hscroll 8:0, vscroll 23:16
    localparam logic [reg_aw-1:0] reg_dump   = 8'h04;  // scr start 8:0, chr start 24:16
    localparam logic [reg_aw-1:0] reg_bank   = 8'h08;  // selectors, extra mask/bits/en
    localparam logic [reg_aw-1:0] reg_misc   = 8'h0C;  // pal_msb, tile_msb

    typedef struct packed {
        logic [8:0]      hscroll;
        logic [7:0]      vscroll;
        logic [8:0]      scr_dump_start;
        logic [8:0]      chr_dump_start;
        logic [3:0][1:0] code_sel;          // code bit 9+i takes attr bit 3+sel
        logic [3:0]      extra_mask;
        logic [3:0]      extra_bits;
        logic            extra_en;
        logic            pal_msb;
        logic            tile_msb;
    } tile_cfg_t;

    // one tile slot, scan to attr
    typedef struct packed {
        logic       layer;      // 0 scroll, 1 fixed
        logic [2:0] row;        // vn[2:0]
        logic       half;       // hn[2]
        logic [8:0] hrender;
        logic [7:0] code_scan;
        logic [7:0] attr_scan;
        logic       last;       // final slot of the layer
    } tile_pos_t;

    // one ROM job, attr to fetch
    typedef struct packed {
        logic              layer;
        logic [rom_aw-1:0] rom_addr;
        logic [3:0]        pal;
        logic [8:0]        hrender;
        logic              last;
    } tile_req_t;

    typedef struct packed {
        logic       layer;
        logic [9:0] addr;       // {line, hrender}
        logic [7:0] din;        // {pal, pixel}
    } line_wr_t;

endpackage

`default_nettype wire

/* logic/tilemap_top.sv */
// tilemap_top: register block and the scan, attr and fetch stages
`timescale 1ns/1ps
`default_nettype none

module tilemap_top #(
    parameter int line_pixels = tilemap_pkg::line_pixels_def
) (
    input  wire                             clk,
    input  wire                             rst,
    // register port
    input  wire [tilemap_pkg::reg_aw-1:0]   awaddr,
    input  wire                             awvalid,
    output logic                            awready,
    input  wire [31:0]                      wdata,
    input  wire [3:0]                       wstrb,
    input  wire                             wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  wire                             bready,
    input  wire [tilemap_pkg::reg_aw-1:0]   araddr,
    input  wire                             arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  wire                             rready,
    // video timing
    input  wire                             lhbl,
    input  wire                             lvbl,
    input  wire [8:0]                       vrender,
    output logic                            line,
    output logic                            done,
    // scan RAM
    output logic [tilemap_pkg::scan_aw-1:0] scan_addr,
    input  wire [7:0]                       code_scan,
    input  wire [7:0]                       attr_scan,
    // graphics ROM
    output logic                            rom_cs,
    output logic [tilemap_pkg::rom_aw-1:0]  rom_addr,
    input  wire                             rom_ok,
    input  wire [15:0]                      rom_data,
    // line buffer
    output logic                            line_we,
    output tilemap_pkg::line_wr_t           line_wr
);

    tilemap_pkg::tile_cfg_t  cfg;
    tilemap_pkg::tile_pos_t  pos;
    tilemap_pkg::tile_req_t  req;
    logic                    pos_valid;
    logic                    pos_ready;
    logic                    req_valid;
    logic                    req_ready;
    logic                    flush;
    logic                    layer_done;

    tile_regs u_regs (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .cfg
    );

    tile_scan #(.line_pixels(line_pixels)) u_scan (
        .clk, .rst, .lhbl, .lvbl, .vrender, .cfg,
        .pos_ready, .code_scan, .attr_scan, .layer_done,
        .scan_addr, .pos_valid, .pos, .line, .done, .flush
    );

    tile_attr u_attr (
        .clk, .rst, .cfg, .pos_valid, .pos, .pos_ready,
        .req_valid, .req, .req_ready, .flush
    );

    tile_fetch u_fetch (
        .clk, .rst, .line, .req_valid, .req, .req_ready,
        .rom_cs, .rom_addr, .rom_ok, .rom_data,
        .line_we, .line_wr, .layer_done, .flush
    );

endmodule

`default_nettype wire

/* testbench/tilemap_models.sv */
// tilemap_models: scan RAM and graphics ROM models with a random rom_ok delay
`timescale 1ns/1ps
`default_nettype none

module tilemap_models (
    input  wire         clk,
    input  wire         delay_en,       // random 0..3 cycle ROM latency
    input  wire [10:0]  scan_addr,
    output logic [7:0]  code_scan,
    output logic [7:0]  attr_scan,
    input  wire         rom_cs,
    input  wire [17:0]  rom_addr,
    output logic        rom_ok,
    output logic [15:0] rom_data
);

    initial begin
        int          wait_cnt;  // cycles left before ok, -1 when no request is open
        logic [31:0] prod;
        wait_cnt  = -1;
        code_scan = 8'h00;
        attr_scan = 8'h00;
        rom_ok    = 1'b0;
        rom_data  = 16'h0000;
        void'($urandom(32'ha6c3));
        forever begin
            @(posedge clk);
            // registered scan read, contents computed from the address
            code_scan <= scan_addr[7:0];
            attr_scan <= scan_addr[7:0] ^ {scan_addr[10:8], 5'd0} ^ 8'h5A;  // upper bits folded
            if (rom_ok) begin
                rom_ok <= 1'b0;         // single cycle pulse
            end else if (rom_cs) begin
                if (wait_cnt < 0) begin
                    wait_cnt = delay_en ? int'($urandom % 4) : 0;
                end
                if (wait_cnt == 0) begin
                    prod     = {14'd0, rom_addr} * 32'h0000_9E37;
                    rom_data <= prod[15:0] ^ prod[31:16];   // product folded to a word
                    rom_ok   <= 1'b1;
                    wait_cnt = -1;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tilemap_tb.sv */
// tilemap_tb: test table, register port tasks, line-buffer capture, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tilemap_tb;

    localparam int lp         = tilemap_pkg::line_pixels_def;
    localparam int axi_limit  = 50;
    localparam int line_limit = 20000;
    localparam int n_rows     = 7;

    typedef struct packed {
        logic [31:0] scroll;
        logic [31:0] dump;
        logic [31:0] bank;
        logic [31:0] misc;
        logic [8:0]  vrender;
        logic        slow_rom;      // random rom_ok delay
        logic [1:0]  passes;        // lines rendered with this row
    } test_row_t;

    logic                   clk;
    logic                   rst;
    logic [7:0]             awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [7:0]             araddr;
    logic                   arvalid;
    logic                   arready;
    logic [31:0]            rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    logic                   lhbl;
    logic                   lvbl;
    logic [8:0]             vrender;
    logic                   line;
    logic                   done;
    logic [10:0]            scan_addr;
    logic [7:0]             code_scan;
    logic [7:0]             attr_scan;
    logic                   rom_cs;
    logic [17:0]            rom_addr;
    logic                   rom_ok;
    logic [15:0]            rom_data;
    logic                   line_we;
    tilemap_pkg::line_wr_t  line_wr;
    logic                   delay_en;

    tilemap_pkg::line_wr_t  got [$];
    tilemap_pkg::line_wr_t  exp [$];
    test_row_t              rows [n_rows];
    string                  names [n_rows];
    int                     errors;
    int                     timeouts;
    int                     checks;
    logic                   line_exp;

    tilemap_top #(.line_pixels(lp)) u_tilemap_top (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .lhbl, .lvbl, .vrender, .line, .done,
        .scan_addr, .code_scan, .attr_scan,
        .rom_cs, .rom_addr, .rom_ok, .rom_data,
        .line_we, .line_wr
    );

    tilemap_models u_models (
        .clk, .delay_en, .scan_addr, .code_scan, .attr_scan,
        .rom_cs, .rom_addr, .rom_ok, .rom_data
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (line_we) begin
            got.push_back(line_wr);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        checks++;
        assert (got_v === exp_v) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp_v, got_v);
            errors++;
        end
    endtask

    task automatic report_timeout(input logic ok, input string what);
        assert (ok) else begin
            $display("timeout: %s", what);
            timeouts++;
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!awready && n < axi_limit);
        report_timeout(awready, "register write address and data not accepted");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        while (!bvalid && n < axi_limit) begin
            @(posedge clk);
            n++;
        end
        report_timeout(bvalid, "no write response from the register port");
        check_value("bresp", 32'd0, {30'd0, bresp});
        bready <= 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < axi_limit);
        report_timeout(arready, "register read address not accepted");
        arvalid <= 1'b0;
        n = 0;
        while (!rvalid && n < axi_limit) begin
            @(posedge clk);
            n++;
        end
        report_timeout(rvalid, "no read data from the register port");
        data = rdata;
        check_value("rresp", 32'd0, {30'd0, rresp});
        rready <= 1'b0;
    endtask

    function automatic logic [31:0] reg_word(input test_row_t r, input int k);
        case (k)
            0:       return r.scroll;
            1:       return r.dump;
            2:       return r.bank;
            default: return r.misc;
        endcase
    endfunction

    // expected line-buffer writes of both layers, in order
    task automatic build_expected(input test_row_t r, input logic line_bit);
        logic [8:0]            hn;
        logic [8:0]            vn;
        logic [8:0]            hr;
        logic [7:0]            attr;
        logic [4:0]            bank;
        logic [17:0]           raddr;
        logic [31:0]           prod;
        logic [15:0]           word;
        logic [3:0]            pal;
        logic                  last;
        tilemap_pkg::line_wr_t w;
        exp.delete();
        for (int layer = 0; layer < 2; layer++) begin
            if (layer == 0) begin
                hn = r.scroll[8:0];
                vn = r.vrender + {1'b0, r.scroll[23:16]};
                hr = r.dump[8:0] - {7'd0, r.scroll[1:0]};
            end else begin
                hn = 9'd0;
                vn = r.vrender;
                hr = r.dump[24:16];
            end
            last = 1'b0;
            while (!last) begin
                // model attr byte, scan address upper bits folded in
                attr    = {vn[5:3], hn[7:3]} ^ {layer[0], vn[7:6], 5'd0} ^ 8'h5A;
                bank[0] = attr[7];
                for (int i = 0; i < 4; i++) begin
                    if (r.bank[16] && r.bank[8 + i]) begin
                        bank[i + 1] = r.bank[12 + i];
                    end else begin
                        bank[i + 1] = attr[3 + r.bank[2*i +: 2]];
                    end
                end
                raddr = {r.misc[1], bank, vn[5:3], hn[7:3], vn[2:0], hn[2]};
                prod  = {14'd0, raddr} * 32'h0000_9E37;
                word  = prod[15:0] ^ prod[31:16];
                pal   = {r.misc[0] & attr[3], attr[2:0]};
                for (int p = 0; p < 4; p++) begin
                    w.layer = layer[0];
                    w.addr  = {line_bit, hr + p[8:0]};
                    w.din   = {pal, word[15 - 4*p -: 4]};     // upper nibble first
                    exp.push_back(w);
                end
                last = (int'(hr) + 4) >= lp;
                hn   = hn + 9'd4;
                hr   = hr + 9'd4;
            end
        end
    endtask

    task automatic render_line(input string name, input test_row_t r);
        int n;
        int cnt_exp [2];
        int cnt_got [2];
        cnt_exp  = '{0, 0};
        cnt_got  = '{0, 0};
        line_exp = ~line_exp;
        build_expected(r, line_exp);
        got.delete();
        @(posedge clk);
        lhbl <= 1'b1;
        @(posedge clk);
        lhbl <= 1'b0;
        n = 0;
        while (done && n < 4) begin
            @(posedge clk);
            n++;
        end
        report_timeout(!done, "done did not fall at line start");
        n = 0;
        while (!done && n < line_limit) begin
            @(posedge clk);
            n++;
        end
        report_timeout(done, "done did not return high after the line");
        check_value({name, " line bit"}, {31'd0, line_exp}, {31'd0, line});
        foreach (exp[i]) cnt_exp[exp[i].layer]++;
        foreach (got[i]) cnt_got[got[i].layer]++;
        check_value({name, " scroll writes"}, cnt_exp[0], cnt_got[0]);
        check_value({name, " fixed writes"}, cnt_exp[1], cnt_got[1]);
        for (int i = 0; i < exp.size() && i < got.size(); i++) begin
            check_value($sformatf("%s write %0d", name, i), {13'd0, exp[i]}, {13'd0, got[i]});
        end
    endtask

    initial begin
        logic [31:0] rd;
        clk      = 1'b0;
        rst      = 1'b1;
        awaddr   = 8'h00;
        awvalid  = 1'b0;
        wdata    = 32'd0;
        wstrb    = 4'h0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = 8'h00;
        arvalid  = 1'b0;
        rready   = 1'b0;
        lhbl     = 1'b0;
        lvbl     = 1'b0;
        vrender  = 9'd0;
        delay_en = 1'b0;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        line_exp = 1'b0;

        //          scroll        dump          bank          misc   vrender slow passes
        rows[0] = '{32'h0005_0010, 32'h0010_0008, 32'h0000_0000, 32'h0, 9'd20, 1'b0, 2'd1};
        rows[1] = '{32'h00F3_0013, 32'h0000_0005, 32'h0000_0000, 32'h1, 9'd100, 1'b0, 2'd1};
        rows[2] = '{32'h00C8_01FE, 32'h0021_0028, 32'h0000_0000, 32'h3, 9'd7, 1'b0, 2'd2};
        rows[3] = '{32'h0020_0004, 32'h0008_0010, 32'h0001_95E4, 32'h2, 9'd60, 1'b0, 2'd1};
        rows[4] = '{32'h0000_0000, 32'h0000_0000, 32'h0000_0F36, 32'h0, 9'd200, 1'b0, 2'd1};
        rows[5] = '{32'h00F3_0013, 32'h0000_0005, 32'h0000_0000, 32'h1, 9'd100, 1'b1, 2'd3};
        rows[6] = '{32'h0010_0021, 32'h013D_0131, 32'h0001_A5E4, 32'h1, 9'd33, 1'b1, 2'd2};
        names[0] = "scroll_aligned";
        names[1] = "scroll_unaligned";
        names[2] = "fixed_layer";
        names[3] = "bank_override";
        names[4] = "code_select";
        names[5] = "rom_backpressure";
        names[6] = "line_end_partial";

        repeat (10) @(posedge clk);
        // done high, every other status output low
        check_value("reset_state", 32'h0000_0100,
                    {23'd0, done, line, rom_cs, line_we, awready, wready, bvalid, arready, rvalid});
        rst  <= 1'b0;
        lvbl <= 1'b1;

        // four registers plus one unmapped word
        for (int a = 0; a < 5; a++) begin
            reg_read(8'(4 * a), rd);
            check_value("reset_value", 32'd0, rd);
        end
        reg_write(8'h10, 32'hFFFF_FFFF);
        reg_read(8'h10, rd);
        check_value("unmapped", 32'd0, rd);

        for (int t = 0; t < n_rows; t++) begin
            for (int k = 0; k < 4; k++) begin
                reg_write(8'(4 * k), reg_word(rows[t], k));
            end
            for (int k = 0; k < 4; k++) begin
                reg_read(8'(4 * k), rd);
                check_value($sformatf("%s reg %0d", names[t], k), reg_word(rows[t], k), rd);
            end
            @(posedge clk);
            delay_en <= rows[t].slow_rom;
            vrender  <= rows[t].vrender;
            for (int p = 0; p < rows[t].passes; p++) begin
                render_line(names[t], rows[t]);
            end
        end

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/tilemap_pkg.sv
logic/tile_regs.sv
logic/tile_scan.sv
logic/tile_attr.sv
logic/tile_fetch.sv
logic/tilemap_top.sv
testbench/tilemap_models.sv
testbench/tilemap_tb.sv
